/* source/aes_gcm_pkg.sv */
package aes_gcm_pkg;

    localparam int AES_BLOCK_BITS = 128;
    localparam int AES_KEY_BITS   = 128;
    localparam int AES_ROUNDS     = 10;
    localparam int AES_SCHED_BITS = (AES_ROUNDS + 1) * AES_BLOCK_BITS;
    localparam int GCM_IV_BITS    = 96;
    localparam int GCM_CTR_BITS   = 32;
    localparam int PIPE_LATENCY   = 12;
    localparam int PIPE_TAIL      = PIPE_LATENCY - AES_ROUNDS - 1; // Registers after round 10.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forward S-box, entry 0 first.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [0:255][7:0] aes_sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Counter block, seen whole or as IV and counter.
    typedef union packed
    {
        logic [0:AES_BLOCK_BITS-1] block;
        struct packed
        {
            logic [0:GCM_IV_BITS-1]  iv;
            logic [0:GCM_CTR_BITS-1] ctr;
        } fields;
    } gcm_block_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] fn_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00); // Multiply by x in GF(2^8).
    endfunction

    function automatic logic [31:0] fn_sub_word(input logic [31:0] w);
        return {aes_sbox[w[31:24]], aes_sbox[w[23:16]], aes_sbox[w[15:8]], aes_sbox[w[7:0]]};
    endfunction

    // SubBytes and ShiftRows together; byte i sits in row i%4, column i/4.
    function automatic logic [0:AES_BLOCK_BITS-1] fn_sub_shift(
        input logic [0:AES_BLOCK_BITS-1] s
    );
        logic [0:AES_BLOCK_BITS-1] t;
        for (int i = 0; i < AES_BLOCK_BITS / 8; i++)
        begin
            t[8*i +: 8] = aes_sbox[s[8*((((i / 4) + (i % 4)) % 4) * 4 + (i % 4)) +: 8]];
        end
        return t;
    endfunction

    function automatic logic [0:31] fn_mix_column(input logic [0:31] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[0:7];
        a1 = col[8:15];
        a2 = col[16:23];
        a3 = col[24:31];
        return {fn_xtime(a0) ^ fn_xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ fn_xtime(a1) ^ fn_xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ fn_xtime(a2) ^ fn_xtime(a3) ^ a3,
                fn_xtime(a0) ^ a0 ^ a1 ^ a2 ^ fn_xtime(a3)};
    endfunction

    function automatic logic [0:AES_BLOCK_BITS-1] fn_aes_round(
        input logic [0:AES_BLOCK_BITS-1] state,
        input logic [0:AES_SCHED_BITS-1] sched,
        input int                        r
    );
        logic [0:AES_BLOCK_BITS-1] s;
        s = state;
        if (r == 1)
            s = s ^ sched[0 +: AES_BLOCK_BITS]; // Initial AddRoundKey.
        s = fn_sub_shift(s);
        if (r != AES_ROUNDS)
        begin
            for (int c = 0; c < 4; c++)
            begin
                s[32*c +: 32] = fn_mix_column(s[32*c +: 32]);
            end
        end
        return s ^ sched[AES_BLOCK_BITS*r +: AES_BLOCK_BITS];
    endfunction

    function automatic logic [0:AES_SCHED_BITS-1] fn_aes_key_expand(
        input logic [0:AES_KEY_BITS-1] key
    );
        logic [0:AES_SCHED_BITS-1] w;
        logic [31:0]               temp;
        logic [7:0]                rcon;
        w[0 +: AES_KEY_BITS] = key;
        rcon = 8'h01;
        for (int i = 4; i < 4 * (AES_ROUNDS + 1); i++)
        begin
            temp = w[32*(i-1) +: 32];
            if (i % 4 == 0)
            begin
                temp = fn_sub_word({temp[23:0], temp[31:24]}) ^ {rcon, 24'h000000};
                rcon = fn_xtime(rcon);
            end
            w[32*i +: 32] = w[32*(i-4) +: 32] ^ temp;
        end
        return w;
    endfunction

endpackage

/* source/aes_key_expand.sv */
module aes_key_expand import aes_gcm_pkg::*; (
    clk,
    i_rst,
    i_valid,
    i_new_instance,
    i_key,
    o_key_schedule
);

    input  logic                      clk;
    input  logic                      i_rst;
    input  logic                      i_valid;
    input  logic                      i_new_instance;
    input  logic [0:AES_KEY_BITS-1]   i_key;

    output logic [0:AES_SCHED_BITS-1] o_key_schedule;

    logic [0:AES_SCHED_BITS-1] w_fresh_schedule;
    logic [0:AES_SCHED_BITS-1] r_held_schedule;
    logic                      w_load;

    assign w_load           = i_valid && i_new_instance;
    assign w_fresh_schedule = fn_aes_key_expand(i_key);

    // Schedule of the current instance.
    always_ff @(posedge clk)
    begin
        if (i_rst)
            r_held_schedule <= '0;
        else if (w_load)
            r_held_schedule <= w_fresh_schedule;
    end

    always_ff @(posedge clk)
    begin
        if (w_load)
            o_key_schedule <= w_fresh_schedule; // First block sees the new key.
        else
            o_key_schedule <= r_held_schedule;
    end

endmodule

/* source/aes_ctr_gen.sv */
module aes_ctr_gen import aes_gcm_pkg::*; (
    clk,
    i_rst,
    i_valid,
    i_new_instance,
    i_iv,
    i_plain_text,
    o_valid,
    o_new_instance,
    o_plain_text,
    o_h,
    o_j0,
    o_cb
);

    input  logic                      clk;
    input  logic                      i_rst;
    input  logic                      i_valid;
    input  logic                      i_new_instance;
    input  logic [0:GCM_IV_BITS-1]    i_iv;
    input  logic [0:AES_BLOCK_BITS-1] i_plain_text;

    output logic                      o_valid;
    output logic                      o_new_instance;
    output logic [0:AES_BLOCK_BITS-1] o_plain_text;
    output logic [0:AES_BLOCK_BITS-1] o_h;
    output logic [0:AES_BLOCK_BITS-1] o_j0;
    output logic [0:AES_BLOCK_BITS-1] o_cb;

    gcm_block_u r_state; // Last counter block issued.
    gcm_block_u w_next;
    gcm_block_u w_j0;

    always_comb
    begin
        if (i_new_instance)
        begin
            w_next.fields.iv  = i_iv;
            w_next.fields.ctr = 32'd2;
        end
        else
        begin
            w_next.fields.iv  = r_state.fields.iv;
            w_next.fields.ctr = r_state.fields.ctr + 32'd1; // Wraps at 2^32.
        end
        w_j0.fields.iv  = w_next.fields.iv;
        w_j0.fields.ctr = 32'd1;
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_state        <= '0;
            o_valid        <= 1'b0;
            o_new_instance <= 1'b0;
        end
        else
        begin
            o_valid        <= i_valid;
            o_new_instance <= i_valid && i_new_instance;
            if (i_valid)
                r_state <= w_next;
        end
    end

    always_ff @(posedge clk)
    begin
        o_plain_text <= i_plain_text;
        o_h          <= '0; // E(K, 0) starts from the zero block.
        o_j0         <= w_j0.block;
        o_cb         <= w_next.block;
    end

endmodule

/* source/aes_round_stage.sv */
module aes_round_stage import aes_gcm_pkg::*; #(
    parameter int ROUND = 1
) (
    clk,
    i_rst,
    i_valid,
    i_new_instance,
    i_plain_text,
    i_h,
    i_j0,
    i_cb,
    i_key_schedule,
    o_valid,
    o_new_instance,
    o_plain_text,
    o_h,
    o_j0,
    o_cb,
    o_key_schedule
);

    input  logic                      clk;
    input  logic                      i_rst;
    input  logic                      i_valid;
    input  logic                      i_new_instance;
    input  logic [0:AES_BLOCK_BITS-1] i_plain_text;
    input  logic [0:AES_BLOCK_BITS-1] i_h;
    input  logic [0:AES_BLOCK_BITS-1] i_j0;
    input  logic [0:AES_BLOCK_BITS-1] i_cb;
    input  logic [0:AES_SCHED_BITS-1] i_key_schedule;

    output logic                      o_valid;
    output logic                      o_new_instance;
    output logic [0:AES_BLOCK_BITS-1] o_plain_text;
    output logic [0:AES_BLOCK_BITS-1] o_h;
    output logic [0:AES_BLOCK_BITS-1] o_j0;
    output logic [0:AES_BLOCK_BITS-1] o_cb;
    output logic [0:AES_SCHED_BITS-1] o_key_schedule;

    logic                      r_valid;
    logic                      r_new_instance;
    logic [0:AES_BLOCK_BITS-1] r_plain_text;
    logic [0:AES_BLOCK_BITS-1] r_h;
    logic [0:AES_BLOCK_BITS-1] r_j0;
    logic [0:AES_BLOCK_BITS-1] r_cb;
    logic [0:AES_SCHED_BITS-1] r_key_schedule;

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_valid        <= 1'b0;
            r_new_instance <= 1'b0;
        end
        else
        begin
            r_valid        <= i_valid;
            r_new_instance <= i_new_instance;
        end
    end

    always_ff @(posedge clk)
    begin
        r_plain_text   <= i_plain_text;
        r_h            <= i_h;
        r_j0           <= i_j0;
        r_cb           <= i_cb;
        r_key_schedule <= i_key_schedule;
    end

    always_comb
    begin
        o_h  = fn_aes_round(r_h, r_key_schedule, ROUND);
        o_j0 = fn_aes_round(r_j0, r_key_schedule, ROUND);
        o_cb = fn_aes_round(r_cb, r_key_schedule, ROUND);

        o_valid        = r_valid; // Carried to the next stage.
        o_new_instance = r_new_instance;
        o_plain_text   = r_plain_text;
        o_key_schedule = r_key_schedule;
    end

endmodule

/* source/aes_gcm_ctr_top.sv */
module aes_gcm_ctr_top import aes_gcm_pkg::*; (
    clk,
    i_rst,
    i_valid,
    i_new_instance,
    i_key,
    i_iv,
    i_plain_text,
    o_valid,
    o_new_instance,
    o_cipher_text,
    o_h,
    o_ek_j0
);

    input  logic                      clk;
    input  logic                      i_rst;
    input  logic                      i_valid;
    input  logic                      i_new_instance;
    input  logic [0:AES_KEY_BITS-1]   i_key;
    input  logic [0:GCM_IV_BITS-1]    i_iv;
    input  logic [0:AES_BLOCK_BITS-1] i_plain_text;

    output logic                      o_valid;
    output logic                      o_new_instance;
    output logic [0:AES_BLOCK_BITS-1] o_cipher_text;
    output logic [0:AES_BLOCK_BITS-1] o_h;
    output logic [0:AES_BLOCK_BITS-1] o_ek_j0;

    // Index 0 is stage 0, index k is the output of round k.
    logic                      s_valid        [0:AES_ROUNDS];
    logic                      s_new_instance [0:AES_ROUNDS];
    logic [0:AES_BLOCK_BITS-1] s_plain_text   [0:AES_ROUNDS];
    logic [0:AES_BLOCK_BITS-1] s_h            [0:AES_ROUNDS];
    logic [0:AES_BLOCK_BITS-1] s_j0           [0:AES_ROUNDS];
    logic [0:AES_BLOCK_BITS-1] s_cb           [0:AES_ROUNDS];
    logic [0:AES_SCHED_BITS-1] s_key_schedule [0:AES_ROUNDS];

    logic                      t_valid        [0:PIPE_TAIL-1];
    logic                      t_new_instance [0:PIPE_TAIL-1];
    logic [0:AES_BLOCK_BITS-1] t_plain_text   [0:PIPE_TAIL-1];
    logic [0:AES_BLOCK_BITS-1] t_h            [0:PIPE_TAIL-1];
    logic [0:AES_BLOCK_BITS-1] t_j0           [0:PIPE_TAIL-1];
    logic [0:AES_BLOCK_BITS-1] t_cb           [0:PIPE_TAIL-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 0 and the round chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    aes_key_expand u_key_expand (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_new_instance (i_new_instance),
        .i_key          (i_key),
        .o_key_schedule (s_key_schedule[0])
    );

    aes_ctr_gen u_ctr_gen (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_new_instance (i_new_instance),
        .i_iv           (i_iv),
        .i_plain_text   (i_plain_text),
        .o_valid        (s_valid[0]),
        .o_new_instance (s_new_instance[0]),
        .o_plain_text   (s_plain_text[0]),
        .o_h            (s_h[0]),
        .o_j0           (s_j0[0]),
        .o_cb           (s_cb[0])
    );

    for (genvar k = 1; k <= AES_ROUNDS; k++)
    begin : g_round
        aes_round_stage #(.ROUND(k)) u_round (
            .clk            (clk),
            .i_rst          (i_rst),
            .i_valid        (s_valid[k-1]),
            .i_new_instance (s_new_instance[k-1]),
            .i_plain_text   (s_plain_text[k-1]),
            .i_h            (s_h[k-1]),
            .i_j0           (s_j0[k-1]),
            .i_cb           (s_cb[k-1]),
            .i_key_schedule (s_key_schedule[k-1]),
            .o_valid        (s_valid[k]),
            .o_new_instance (s_new_instance[k]),
            .o_plain_text   (s_plain_text[k]),
            .o_h            (s_h[k]),
            .o_j0           (s_j0[k]),
            .o_cb           (s_cb[k]),
            .o_key_schedule (s_key_schedule[k])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tail registers and output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < PIPE_TAIL; i++)
            begin
                t_valid[i]        <= 1'b0;
                t_new_instance[i] <= 1'b0;
            end
        end
        else
        begin
            t_valid[0]        <= s_valid[AES_ROUNDS];
            t_new_instance[0] <= s_new_instance[AES_ROUNDS];
            for (int i = 1; i < PIPE_TAIL; i++)
            begin
                t_valid[i]        <= t_valid[i-1];
                t_new_instance[i] <= t_new_instance[i-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        t_plain_text[0] <= s_plain_text[AES_ROUNDS];
        t_h[0]          <= s_h[AES_ROUNDS];
        t_j0[0]         <= s_j0[AES_ROUNDS];
        t_cb[0]         <= s_cb[AES_ROUNDS];
        for (int i = 1; i < PIPE_TAIL; i++)
        begin
            t_plain_text[i] <= t_plain_text[i-1];
            t_h[i]          <= t_h[i-1];
            t_j0[i]         <= t_j0[i-1];
            t_cb[i]         <= t_cb[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            o_valid        <= 1'b0;
            o_new_instance <= 1'b0;
            o_h            <= '0;
            o_ek_j0        <= '0;
        end
        else
        begin
            o_valid        <= t_valid[PIPE_TAIL-1];
            o_new_instance <= t_valid[PIPE_TAIL-1] && t_new_instance[PIPE_TAIL-1];
            if (t_valid[PIPE_TAIL-1] && t_new_instance[PIPE_TAIL-1])
            begin
                o_h     <= t_h[PIPE_TAIL-1]; // Held for the whole instance.
                o_ek_j0 <= t_j0[PIPE_TAIL-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        o_cipher_text <= t_plain_text[PIPE_TAIL-1] ^ t_cb[PIPE_TAIL-1]; // CTR keystream XOR.
    end

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
    o_clk
);

    output logic o_clk;

    localparam int HALF_PERIOD = 20; // Period of 40.

    initial
    begin
        o_clk = 1'b0;
        forever
            #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

/* tb/aes_gcm_properties.sv */
module aes_gcm_properties import aes_gcm_pkg::*; (
    clk,
    i_rst,
    i_valid,
    o_valid,
    o_new_instance
);

    input logic clk;
    input logic i_rst;
    input logic i_valid;
    input logic o_valid;
    input logic o_new_instance;

    int quiet_cycles = 0; // Edges since the last reset edge.
    int failures     = 0;

    always @(posedge clk)
    begin
        if (i_rst)
            quiet_cycles <= 0;
        else if (quiet_cycles <= PIPE_LATENCY)
            quiet_cycles <= quiet_cycles + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output strobe rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_valid_in_reset: assert property (@(posedge clk) i_rst |=> !o_valid)
    else
    begin
        $error("o_valid is high after a reset edge");
        failures++;
    end

    // o_valid rises after edge N+12, so the next edge sees it.
    a_valid_latency: assert property (@(posedge clk)
        (quiet_cycles > PIPE_LATENCY) |-> (o_valid == $past(i_valid, PIPE_LATENCY + 1)))
    else
    begin
        $error("o_valid does not follow i_valid by the pipeline latency");
        failures++;
    end

    a_new_needs_valid: assert property (@(posedge clk) o_new_instance |-> o_valid)
    else
    begin
        $error("o_new_instance is high without o_valid");
        failures++;
    end

endmodule

/* tb/aes_gcm_tb.sv */
module aes_gcm_tb import aes_gcm_pkg::*; ();

    localparam int     CLK_PERIOD    = 40;
    localparam int     TEST_COUNT    = 5;
    localparam int     BLOCKS_DRIVEN = 26;
    localparam int     MARGIN_CYCLES = 40;
    localparam int     WAIT_LIMIT    = PIPE_LATENCY + 20;
    localparam longint WATCHDOG_TIME =
        (BLOCKS_DRIVEN + PIPE_LATENCY + MARGIN_CYCLES) * CLK_PERIOD * TEST_COUNT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // GCM test cases 2 and 3
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [0:AES_BLOCK_BITS-1] TC2_H      = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam logic [0:AES_BLOCK_BITS-1] TC2_EK_J0  = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam logic [0:AES_BLOCK_BITS-1] TC2_CIPHER = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam logic [0:AES_KEY_BITS-1]   TC3_KEY    = 128'hfeffe9928665731c6d6a8f9467308308;
    localparam logic [0:GCM_IV_BITS-1]    TC3_IV     = 96'hcafebabefacedbaddecaf888;
    localparam logic [0:AES_BLOCK_BITS-1] TC3_H      = 128'hb83b533708bf535d0aa6e52980d53b78;
    localparam logic [0:AES_BLOCK_BITS-1] TC3_EK_J0  = 128'h3247184b3c4f69a44dbcd22887bbb418;
    localparam logic [0:AES_BLOCK_BITS-1] TC3_PLAIN [0:3] = '{
        128'hd9313225f88406e5a55909c5aff5269a,
        128'h86a7a9531534f7da2e4c303d8a318a72,
        128'h1c3c0c95956809532fcf0e2449a6b525,
        128'hb16aedf5aa0de657ba637b391aafd255
    };
    localparam logic [0:AES_BLOCK_BITS-1] TC3_CIPHER [0:3] = '{
        128'h42831ec2217774244b7221b784d0d49c,
        128'he3aa212f2c02a4e035c17e2329aca12e,
        128'h21d514b25466931c7d8f6a5aac84aa05,
        128'h1ba30b396a0aac973d58e091473f5985
    };

    logic                      clk;
    logic                      i_rst;
    logic                      i_valid;
    logic                      i_new_instance;
    logic [0:AES_KEY_BITS-1]   i_key;
    logic [0:GCM_IV_BITS-1]    i_iv;
    logic [0:AES_BLOCK_BITS-1] i_plain_text;
    logic                      o_valid;
    logic                      o_new_instance;
    logic [0:AES_BLOCK_BITS-1] o_cipher_text;
    logic [0:AES_BLOCK_BITS-1] o_h;
    logic [0:AES_BLOCK_BITS-1] o_ek_j0;

    int                        value_errors = 0;
    int                        other_errors = 0;
    int                        check_count  = 0;
    int                        cycle_count  = 0;
    logic [31:0]               lfsr_state   = 32'h8afb;

    logic [0:AES_BLOCK_BITS-1] got_cipher [$];
    logic                      got_new    [$];
    int                        got_edge   [$];
    logic [0:AES_BLOCK_BITS-1] got_h      [$];
    logic [0:AES_BLOCK_BITS-1] got_ek_j0  [$];
    int                        sent_edge  [$];
    logic [0:AES_BLOCK_BITS-1] exp_cipher [$];
    logic                      exp_new    [$];

    tb_clock_gen u_clock_gen (
        .o_clk (clk)
    );

    aes_gcm_ctr_top uut (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_new_instance (i_new_instance),
        .i_key          (i_key),
        .i_iv           (i_iv),
        .i_plain_text   (i_plain_text),
        .o_valid        (o_valid),
        .o_new_instance (o_new_instance),
        .o_cipher_text  (o_cipher_text),
        .o_h            (o_h),
        .o_ek_j0        (o_ek_j0)
    );

    bind aes_gcm_ctr_top aes_gcm_properties u_properties (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .o_valid        (o_valid),
        .o_new_instance (o_new_instance)
    );

    always @(posedge clk)
        cycle_count <= cycle_count + 1; // Index of the last rising edge.

    // Output monitor, sampled on the falling edge.
    always @(negedge clk)
    begin
        if (o_valid === 1'b1)
        begin
            got_cipher.push_back(o_cipher_text);
            got_new.push_back(o_new_instance);
            got_edge.push_back(cycle_count);
            got_h.push_back(o_h);
            got_ek_j0.push_back(o_ek_j0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and compare helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_random_block(output logic [0:AES_BLOCK_BITS-1] b);
        for (int i = 0; i < AES_BLOCK_BITS; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    task automatic check_block(input string name, input logic [0:AES_BLOCK_BITS-1] got,
                               input logic [0:AES_BLOCK_BITS-1] exp);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        check_count++;
        if (got != exp)
        begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        $display("test: %s", name);
        got_cipher.delete();
        got_new.delete();
        got_edge.delete();
        got_h.delete();
        got_ek_j0.delete();
        sent_edge.delete();
        exp_cipher.delete();
        exp_new.delete();
    endtask

    task automatic send_block(input logic new_inst, input logic [0:AES_KEY_BITS-1] key,
                              input logic [0:GCM_IV_BITS-1] iv,
                              input logic [0:AES_BLOCK_BITS-1] pt);
        i_valid        = 1'b1;
        i_new_instance = new_inst;
        i_key          = key;
        i_iv           = iv;
        i_plain_text   = pt;
        sent_edge.push_back(cycle_count + 1); // Sampled at the next rising edge.
        @(negedge clk);
        i_valid        = 1'b0;
        i_new_instance = 1'b0;
    endtask

    task automatic wait_outputs(input int count);
        int waited;
        waited = 0;
        while (got_cipher.size() < count && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (got_cipher.size() < count)
        begin
            other_errors++;
            $display("o_valid did not arrive: %0d of %0d blocks came out in %0d cycles",
                     got_cipher.size(), count, WAIT_LIMIT);
        end
        @(negedge clk);
    endtask

    task automatic check_outputs();
        for (int i = 0; i < exp_cipher.size() && i < got_cipher.size(); i++)
        begin
            check_block($sformatf("o_cipher_text[%0d]", i), got_cipher[i], exp_cipher[i]);
            check_flag($sformatf("o_new_instance[%0d]", i), got_new[i], exp_new[i]);
            check_cycles($sformatf("latency[%0d]", i), got_edge[i] - sent_edge[i],
                         PIPE_LATENCY);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_zero_key();
        start_test("zero key, hash subkey and E(K, J0)");
        send_block(1'b1, '0, '0, '0);
        exp_cipher.push_back(TC2_CIPHER);
        exp_new.push_back(1'b1);
        wait_outputs(1);
        check_outputs();
        if (got_h.size() > 0)
        begin
            check_block("o_h", got_h[0], TC2_H);
            check_block("o_ek_j0", got_ek_j0[0], TC2_EK_J0);
        end
    endtask

    task automatic test_nonzero_key();
        start_test("nonzero key and IV, first block");
        send_block(1'b1, TC3_KEY, TC3_IV, TC3_PLAIN[0]);
        exp_cipher.push_back(TC3_CIPHER[0]);
        exp_new.push_back(1'b1);
        wait_outputs(1);
        check_outputs();
        if (got_h.size() > 0)
        begin
            check_block("o_h", got_h[0], TC3_H);
            check_block("o_ek_j0", got_ek_j0[0], TC3_EK_J0);
        end
    endtask

    task automatic test_throughput();
        logic [0:AES_BLOCK_BITS-1] pt;
        start_test("back-to-back new instances");
        for (int i = 0; i < 16; i++)
        begin
            draw_random_block(pt);
            send_block(1'b1, '0, '0, pt);
            exp_cipher.push_back(pt ^ TC2_CIPHER); // Keystream of counter 2.
            exp_new.push_back(1'b1);
        end
        wait_outputs(16);
        check_outputs();
    endtask

    task automatic test_counter_run();
        gcm_block_u cb;
        start_test("counter continuation within an instance");
        cb.fields.iv = TC3_IV;
        for (int i = 0; i < 4; i++)
        begin
            cb.fields.ctr = i + 2;
            // Later blocks carry a zero key and IV, which must be ignored.
            send_block(i == 0, (i == 0) ? TC3_KEY : '0, (i == 0) ? TC3_IV : '0,
                       TC3_PLAIN[i]);
            check_block($sformatf("counter block[%0d]", i), uut.u_ctr_gen.o_cb, cb.block);
            exp_cipher.push_back(TC3_CIPHER[i]);
            exp_new.push_back(i == 0);
        end
        wait_outputs(4);
        check_outputs();
        for (int i = 0; i < got_h.size(); i++)
        begin
            check_block($sformatf("o_h[%0d]", i), got_h[i], TC3_H);
            check_block($sformatf("o_ek_j0[%0d]", i), got_ek_j0[i], TC3_EK_J0);
        end
    endtask

    task automatic test_reset();
        start_test("reset in mid stream");
        for (int i = 0; i < 4; i++)
            send_block(i == 0, TC3_KEY, TC3_IV, TC3_PLAIN[i]);
        repeat (3) @(negedge clk);
        i_rst = 1'b1;
        repeat (5)
        begin
            @(negedge clk);
            check_flag("o_valid in reset", o_valid, 1'b0);
        end
        i_rst = 1'b0;
        repeat (PIPE_LATENCY)
        begin
            @(negedge clk);
            check_flag("o_valid after reset", o_valid, 1'b0);
            check_block("o_h after reset", o_h, '0);
            check_block("o_ek_j0 after reset", o_ek_j0, '0);
        end
        if (got_cipher.size() != 0)
        begin
            other_errors++;
            $display("blocks in flight at reset still came out of the pipeline");
        end
    endtask

    initial
    begin
        #(WATCHDOG_TIME);
        $display("watchdog expired: the run did not finish within %0d time units",
                 WATCHDOG_TIME);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        i_rst          = 1'b1;
        i_valid        = 1'b0;
        i_new_instance = 1'b0;
        i_key          = '0;
        i_iv           = '0;
        i_plain_text   = '0;
        repeat (5) @(negedge clk);
        i_rst = 1'b0;
        @(negedge clk);

        test_zero_key();
        test_nonzero_key();
        test_throughput();
        test_counter_run();
        test_reset();

        other_errors += uut.u_properties.failures;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 check_count, value_errors, other_errors, uut.u_properties.failures);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog.f */
source/aes_gcm_pkg.sv
source/aes_key_expand.sv
source/aes_ctr_gen.sv
source/aes_round_stage.sv
source/aes_gcm_ctr_top.sv
tb/tb_clock_gen.sv
tb/aes_gcm_properties.sv
tb/aes_gcm_tb.sv
